// ==== dv/ntm_vectors.txt ====
# M modulus I J starts a matrix, all fields in hex
# E a b product gives one element in row-major order, product is a*b mod modulus
M fff1 01 01
E fff0 fff0 0001
M 0007 01 03
E 0003 0005 0001
E 0006 0006 0001
E 0000 0004 0000
M 8000 03 01
E 7fff 7fff 0001
E 1234 0002 2468
E 4000 0003 4000
M 03e9 03 04
E 03e8 03e8 0001
E 01f4 0002 03e8
E 01f4 0003 01f3
E 007b 01c8 0020
E 03e7 03e7 0004
E 0001 0309 0309
E 0000 03e8 0000
E 00fa 0004 03e8
E 004d 000d 0000
E 0064 0064 03df
E 0200 0200 0373
E 0141 028e 02d5

// ==== files.f ====
+incdir+include
rtl/ntm_data_pkg.sv
rtl/ntm_ctrl_pkg.sv
rtl/ntm_mul_if.sv
rtl/ntm_operand_latch.sv
rtl/ntm_modular_multiplier.sv
rtl/ntm_matrix_sequencer.sv
rtl/ntm_matrix_multiplier.sv
dv/ntm_matrix_multiplier_sva.sv
dv/ntm_matrix_multiplier_tb.sv

// ==== Bender.yml ====
package:
  name: ntm_matrix_multiplier

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/ntm_data_pkg.sv
      - rtl/ntm_ctrl_pkg.sv
      - rtl/ntm_mul_if.sv
      - rtl/ntm_operand_latch.sv
      - rtl/ntm_modular_multiplier.sv
      - rtl/ntm_matrix_sequencer.sv
      - rtl/ntm_matrix_multiplier.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/ntm_matrix_multiplier_sva.sv
      - dv/ntm_matrix_multiplier_tb.sv

// ==== dv/ntm_matrix_multiplier_tb.sv ====
//////////////////////////////////////////////////////////////////////
// NTM matrix multiplier testbench
// Streams matrices from the vector file with random operand gaps and
// credit returns, checks products, markers, credits and idle
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ntm_config.svh"

module ntm_matrix_multiplier_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ntm_data_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  // Longest random gap for operands and credit returns
  localparam int MAX_DELAY    = 3;
  // Long enough for several results to leak if the credit gate fails
  localparam int HOLD_CYCLES  = 3 * (`NTM_DATA_WIDTH + 1);
  localparam int MAX_ELEMS    = 256;

  logic   CLK;
  logic   RST;
  logic   start;
  index_t size_i;
  index_t size_j;
  data_t  modulus;
  logic   idle;
  logic   operand_credit;
  logic   a_valid;
  data_t  a_data;
  logic   b_valid;
  data_t  b_data;
  logic   out_valid;
  data_t  out_data;
  logic   out_row_end;
  logic   out_last;
  logic   out_credit;

  // Matrices and elements from the vector file
  data_t  mat_mod [MAX_ELEMS];
  index_t mat_i [MAX_ELEMS];
  index_t mat_j [MAX_ELEMS];
  int     mat_first [MAX_ELEMS];
  data_t  elem_a [MAX_ELEMS];
  data_t  elem_b [MAX_ELEMS];
  data_t  elem_p [MAX_ELEMS];
  int     num_mats;
  int     num_elems;

  // Expected results, row-major
  data_t  exp_data_q[$];
  logic   exp_row_end_q[$];
  logic   exp_last_q[$];

  // Monitor counters move at posedge, driver counters at negedge
  int     credits_granted;
  int     credits_used;
  int     outputs_seen;
  int     returns_seen;
  int     returns_given;
  int     matrices_done;
  int     watchdog_cycles;
  logic   withhold;
  logic   idle_due;
  logic   loaded;
  integer seed = 32'hdc01_fe44;
  integer credit_seed;

  ntm_matrix_multiplier i_ntm_matrix_multiplier (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .size_i        (size_i),
    .size_j        (size_j),
    .modulus       (modulus),
    .idle          (idle),
    .operand_credit(operand_credit),
    .a_valid       (a_valid),
    .a_data        (a_data),
    .b_valid       (b_valid),
    .b_data        (b_data),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_row_end   (out_row_end),
    .out_last      (out_last),
    .out_credit    (out_credit)
  );

  // Credit rule assertions on the DUT
  bind ntm_matrix_multiplier ntm_matrix_multiplier_sva i_ntm_matrix_multiplier_sva (
    .CLK           (CLK),
    .RST           (RST),
    .operand_credit(operand_credit),
    .pair_take     (mul_if.pair_take),
    .out_valid     (out_valid),
    .out_credit    (out_credit)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Error reporting and compares
  //////////////////////////////////////////////////////////////////////
  task automatic report_error(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      report_error($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Header lines M, element lines E, hash lines skipped
  task automatic load_vectors();
    int    fd;
    int    fields;
    int    total;
    int    f1;
    int    f2;
    int    f3;
    byte   tag;
    string line;
    fd = $fopen("dv/ntm_vectors.txt", "r");
    if (fd == 0) begin
      report_error("cannot open the vector file dv/ntm_vectors.txt");
    end
    total = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      fields = $sscanf(line, "%c %h %h %h", tag, f1, f2, f3);
      if (fields != 4 || (tag != "M" && tag != "E") || (tag == "E" && num_mats == 0)) begin
        report_error($sformatf("malformed vector line %s", line));
      end
      if (tag == "M") begin
        mat_mod[num_mats]   = data_t'(f1);
        mat_i[num_mats]     = index_t'(f2);
        mat_j[num_mats]     = index_t'(f3);
        mat_first[num_mats] = num_elems;
        total += f2 * f3;
        num_mats++;
      end else begin
        // Listed product must be a*b mod m
        if (longint'(f3) != (longint'(f1) * longint'(f2)) % longint'(mat_mod[num_mats - 1])) begin
          report_error($sformatf("vector product is not a*b mod m on line %s", line));
        end
        elem_a[num_elems] = data_t'(f1);
        elem_b[num_elems] = data_t'(f2);
        elem_p[num_elems] = data_t'(f3);
        num_elems++;
      end
    end
    $fclose(fd);
    if (total != num_elems) begin
      report_error("vector file element count does not match the matrix sizes");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  // One A and one B per granted credit, random order and gaps
  task automatic drive_operands(input int first, input int count);
    int k;
    int t;
    int da;
    int db;
    for (k = 0; k < count; k++) begin
      while (credits_granted <= credits_used) begin
        @(negedge CLK);
      end
      credits_used++;
      da = {$random(seed)} % (MAX_DELAY + 1);
      db = {$random(seed)} % (MAX_DELAY + 1);
      for (t = 0; t <= ((da > db) ? da : db); t++) begin
        a_valid = (t == da);
        b_valid = (t == db);
        a_data  = elem_a[first + k];
        b_data  = elem_b[first + k];
        @(negedge CLK);
      end
      a_valid = 1'b0;
      b_valid = 1'b0;
    end
  endtask

  // Pool drains, output must stall, then credits flow again
  task automatic hold_output_credits(input int base);
    wait (outputs_seen == base + `NTM_OUT_CREDITS);
    repeat (HOLD_CYCLES) @(negedge CLK);
    if (outputs_seen != base + `NTM_OUT_CREDITS) begin
      report_error($sformatf("%0d results came out while only %0d credits were granted",
                             outputs_seen - base, `NTM_OUT_CREDITS));
    end
    withhold = 1'b0;
  endtask

  // Consumer returns one credit per result after a random gap
  initial begin : credit_return
    int gap;
    gap = 0;
    forever begin
      @(negedge CLK);
      out_credit = 1'b0;
      if (!withhold && returns_given < outputs_seen) begin
        if (gap == 0) begin
          out_credit = 1'b1;
          returns_given++;
          gap = {$random(credit_seed)} % (MAX_DELAY + 1);
        end else begin
          gap--;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output monitor, samples the values settled during the last cycle
  //////////////////////////////////////////////////////////////////////
  always @(posedge CLK) begin
    if (!RST) begin
      if (i_ntm_matrix_multiplier.i_ntm_matrix_multiplier_sva.fail_count != 0) begin
        report_error("a credit assertion in the bound checker failed");
      end
      if (idle_due) begin
        check_flag("idle", idle, 1'b1);
        idle_due = 1'b0;
      end
      if (out_valid) begin
        if (`NTM_OUT_CREDITS - outputs_seen + returns_seen <= 0) begin
          report_error("result emitted while the output credit pool was empty");
        end
        if (exp_data_q.size() == 0) begin
          report_error("result emitted with no element pending");
        end
        check_data("out_data", out_data, exp_data_q.pop_front());
        check_flag("out_row_end", out_row_end, exp_row_end_q.pop_front());
        check_flag("out_last", out_last, exp_last_q.pop_front());
        outputs_seen++;
        if (out_last) begin
          idle_due = 1'b1;
          matrices_done++;
        end
      end else begin
        check_flag("out_row_end", out_row_end, 1'b0);
        check_flag("out_last", out_last, 1'b0);
      end
      if (operand_credit) begin
        credits_granted++;
      end
      if (out_credit) begin
        returns_seen++;
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (watchdog_cycles) @(posedge CLK);
    report_error("watchdog timeout, the matrices did not complete in time");
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin : main
    int   m;
    int   k;
    int   first;
    int   count;
    int   base_out;
    int   base_granted;
    int   done_before;
    logic hold_now;
    logic hold_done;
    RST        = 1'b1;
    start      = 1'b0;
    size_i     = '0;
    size_j     = '0;
    modulus    = '0;
    a_valid    = 1'b0;
    a_data     = '0;
    b_valid    = 1'b0;
    b_data     = '0;
    out_credit = 1'b0;
    withhold   = 1'b0;
    idle_due   = 1'b0;
    loaded     = 1'b0;
    hold_done  = 1'b0;
    credit_seed = $random(seed);
    load_vectors();
    watchdog_cycles = RESET_CYCLES + HOLD_CYCLES
                      + num_elems * (4 * (`NTM_DATA_WIDTH + 1) + MAX_DELAY);
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge CLK);
    RST = 1'b0;
    // Reset state
    check_flag("idle", idle, 1'b1);
    check_flag("operand_credit", operand_credit, 1'b0);
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("out_row_end", out_row_end, 1'b0);
    check_flag("out_last", out_last, 1'b0);
    for (m = 0; m < num_mats; m++) begin
      first = mat_first[m];
      count = int'(mat_i[m]) * int'(mat_j[m]);
      for (k = 0; k < count; k++) begin
        exp_data_q.push_back(elem_p[first + k]);
        exp_row_end_q.push_back((k % int'(mat_j[m])) == int'(mat_j[m]) - 1);
        exp_last_q.push_back(k == count - 1);
      end
      // First matrix bigger than the pool runs with credits withheld
      hold_now = !hold_done && (count > `NTM_OUT_CREDITS);
      if (hold_now) begin
        wait (returns_given == outputs_seen);
        withhold  = 1'b1;
        hold_done = 1'b1;
      end
      base_out     = outputs_seen;
      base_granted = credits_granted;
      done_before  = matrices_done;
      @(negedge CLK);
      start   = 1'b1;
      size_i  = mat_i[m];
      size_j  = mat_j[m];
      modulus = mat_mod[m];
      @(negedge CLK);
      start = 1'b0;
      fork
        drive_operands(first, count);
        if (hold_now) hold_output_credits(base_out);
      join
      wait (matrices_done > done_before);
      @(negedge CLK);
      if (outputs_seen - base_out != count) begin
        report_error($sformatf("matrix %0d gave %0d results for %0d elements",
                               m, outputs_seen - base_out, count));
      end
      if (credits_granted - base_granted != count) begin
        report_error($sformatf("matrix %0d granted %0d operand credits for %0d elements",
                               m, credits_granted - base_granted, count));
      end
    end
    // Let the idle check after the last result run
    @(negedge CLK);
    if (exp_data_q.size() != 0) begin
      report_error("expected results still pending at the end of the run");
    end
    if (i_ntm_matrix_multiplier.i_ntm_matrix_multiplier_sva.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end
endmodule

`default_nettype wire

// ==== dv/ntm_matrix_multiplier_sva.sv ====
//////////////////////////////////////////////////////////////////////
// NTM matrix multiplier credit assertions
// Output credit gate and operand credit accounting in the DUT
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ntm_config.svh"

module ntm_matrix_multiplier_sva (
  input logic CLK,
  input logic RST,
  input logic operand_credit,
  input logic pair_take,
  input logic out_valid,
  input logic out_credit
);
  timeunit 1ns;
  timeprecision 1ps;

  // Credits the consumer holds for the design
  int out_credits;
  // Operand credits granted and pairs the multiplier took so far
  int op_granted;
  int pairs_taken;
  // Read by the testbench
  int fail_count = 0;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_credits <= `NTM_OUT_CREDITS;
      op_granted  <= 0;
      pairs_taken <= 0;
    end else begin
      out_credits <= out_credits - int'(out_valid) + int'(out_credit);
      op_granted  <= op_granted + int'(operand_credit);
      pairs_taken <= pairs_taken + int'(pair_take);
    end
  end

  // No result without a credit
  out_credit_gate: assert property (@(posedge CLK) disable iff (RST)
    out_valid |-> out_credits > 0)
    else begin
      fail_count++;
      $error("out_valid raised with no output credit");
    end

  // Operand pairs never ahead of the credits granted
  pair_credit_gate: assert property (@(posedge CLK) disable iff (RST)
    pair_take |-> pairs_taken < op_granted)
    else begin
      fail_count++;
      $error("operand pair taken beyond the operand credits granted");
    end
endmodule

`default_nettype wire

// ==== rtl/ntm_matrix_multiplier.sv ====
//////////////////////////////////////////////////////////////////////
// NTM element-wise modular matrix multiplier
// out(i,j) = a(i,j) * b(i,j) mod modulus over a streamed I by J matrix
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ntm_matrix_multiplier (
  input  logic                 CLK,
  input  logic                 RST,
  // Matrix control
  input  logic                 start,
  input  ntm_data_pkg::index_t size_i,
  input  ntm_data_pkg::index_t size_j,
  input  ntm_data_pkg::data_t  modulus,
  output logic                 idle,
  // Operand stream
  output logic                 operand_credit,
  input  logic                 a_valid,
  input  ntm_data_pkg::data_t  a_data,
  input  logic                 b_valid,
  input  ntm_data_pkg::data_t  b_data,
  // Result stream
  output logic                 out_valid,
  output ntm_data_pkg::data_t  out_data,
  output logic                 out_row_end,
  output logic                 out_last,
  input  logic                 out_credit
);

  ntm_mul_if mul_if ();

  // Operand pairing
  ntm_operand_latch i_ntm_operand_latch (
    .CLK    (CLK),
    .RST    (RST),
    .a_valid(a_valid),
    .b_valid(b_valid),
    .a_data (a_data),
    .b_data (b_data),
    .mul    (mul_if.latch)
  );

  // Product mod modulus
  ntm_modular_multiplier i_ntm_modular_multiplier (
    .CLK(CLK),
    .RST(RST),
    .mul(mul_if.mult)
  );

  // Matrix walk and credits
  ntm_matrix_sequencer i_ntm_matrix_sequencer (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .size_i        (size_i),
    .size_j        (size_j),
    .modulus_in    (modulus),
    .out_credit    (out_credit),
    .idle          (idle),
    .operand_credit(operand_credit),
    .out_valid     (out_valid),
    .out_row_end   (out_row_end),
    .out_last      (out_last),
    .out_data      (out_data),
    .mul           (mul_if.seq)
  );
endmodule

`default_nettype wire

// ==== rtl/ntm_matrix_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// NTM matrix sequencer
// Walks the I by J matrix, grants operand credits and emits results
// against the consumer's output credits
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ntm_config.svh"

module ntm_matrix_sequencer (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  ntm_data_pkg::index_t size_i,
  input  ntm_data_pkg::index_t size_j,
  input  ntm_data_pkg::data_t  modulus_in,
  input  logic                 out_credit,
  output logic                 idle,
  output logic                 operand_credit,
  output logic                 out_valid,
  output logic                 out_row_end,
  output logic                 out_last,
  output ntm_data_pkg::data_t  out_data,
  ntm_mul_if.seq               mul
);
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;

  seq_state_t state;
  credit_t    credits;

  // Matrix bounds, sampled at start
  index_t last_i;
  index_t last_j;
  data_t  modulus_q;

  // Input side, element of the latest credit
  index_t in_i;
  index_t in_j;
  logic   in_last;
  // Output side, element being emitted
  index_t out_i;
  index_t out_j;

  assign in_last = (in_i == last_i) && (in_j == last_j);

  assign idle            = (state == SEQ_IDLE);
  assign out_row_end     = out_valid && (out_j == last_j);
  assign out_last        = out_row_end && (out_i == last_i);
  assign out_data        = mul.product;
  assign mul.result_take = out_valid;
  assign mul.modulus     = modulus_q;

  always_ff @(posedge CLK) begin
    if (start && idle) begin
      last_i    <= size_i - 1'b1;
      last_j    <= size_j - 1'b1;
      modulus_q <= modulus_in;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // FSM, indices and credits
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= SEQ_IDLE;
      credits        <= credit_t'(`NTM_OUT_CREDITS);
      operand_credit <= 1'b0;
      out_valid      <= 1'b0;
      in_i           <= '0;
      in_j           <= '0;
      out_i          <= '0;
      out_j          <= '0;
    end else begin
      operand_credit <= 1'b0;
      // Emit one cycle after the result shows, never without a credit
      out_valid <= mul.result_valid && !out_valid && (credits != '0) && !idle;
      credits   <= credits - credit_t'(out_valid) + credit_t'(out_credit);
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            state          <= SEQ_RUN;
            operand_credit <= 1'b1;
            in_i           <= '0;
            in_j           <= '0;
            out_i          <= '0;
            out_j          <= '0;
          end
        end
        SEQ_RUN: begin
          // All I*J credits out
          if (in_last) begin
            state <= SEQ_DRAIN;
          end else if (mul.pair_take) begin
            operand_credit <= 1'b1;
            in_j           <= (in_j == last_j) ? '0 : in_j + 1'b1;
            in_i           <= (in_j == last_j) ? in_i + 1'b1 : in_i;
          end
        end
        SEQ_DRAIN: ;
        default: state <= SEQ_IDLE;
      endcase
      // Output walk in row-major order
      if (out_valid) begin
        out_j <= out_row_end ? '0 : out_j + 1'b1;
        out_i <= out_row_end ? out_i + 1'b1 : out_i;
        if (out_last) begin
          state <= SEQ_IDLE;
        end
      end
    end
  end
endmodule

`default_nettype wire

// ==== rtl/ntm_modular_multiplier.sv ====
//////////////////////////////////////////////////////////////////////
// NTM modular multiplier
// Bit-serial interleaved shift-add a*b mod m, MSB of b first
// Result held until the sequencer takes it
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ntm_config.svh"

module ntm_modular_multiplier (
  input  logic    CLK,
  input  logic    RST,
  ntm_mul_if.mult mul
);
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;

  localparam int BIT_CNT_W = $clog2(`NTM_DATA_WIDTH);

  mul_state_t           state;
  logic [BIT_CNT_W-1:0] bit_cnt;

  // Operands, b shifts left one bit per step
  data_t a_q;
  data_t b_q;
  // Partial result, doubles as the hold register
  data_t acc;

  // Two guard bits, 2*acc + a stays below 3*m
  logic [`NTM_DATA_WIDTH+1:0] m_ext;
  logic [`NTM_DATA_WIDTH+1:0] step_sum;
  logic [`NTM_DATA_WIDTH+1:0] step_red1;
  logic [`NTM_DATA_WIDTH+1:0] step_red2;

  assign m_ext = {2'b00, mul.modulus};

  // One interleaved step
  always_comb begin
    step_sum  = {1'b0, acc, 1'b0} + (b_q[`NTM_DATA_WIDTH-1] ? {2'b00, a_q} : '0);
    step_red1 = (step_sum >= m_ext) ? step_sum - m_ext : step_sum;
    step_red2 = (step_red1 >= m_ext) ? step_red1 - m_ext : step_red1;
  end

  assign mul.pair_take    = (state == MUL_FREE) && mul.pair_valid;
  assign mul.result_valid = (state == MUL_HOLD);
  assign mul.product      = acc;

  ////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= MUL_FREE;
      bit_cnt <= '0;
    end else begin
      case (state)
        MUL_FREE: begin
          if (mul.pair_take) begin
            state   <= MUL_BUSY;
            bit_cnt <= BIT_CNT_W'(`NTM_DATA_WIDTH - 1);
          end
        end
        MUL_BUSY: begin
          bit_cnt <= bit_cnt - 1'b1;
          // Last bit done
          if (bit_cnt == '0) begin
            state <= MUL_HOLD;
          end
        end
        MUL_HOLD: begin
          if (mul.result_take) begin
            state <= MUL_FREE;
          end
        end
        default: state <= MUL_FREE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (mul.pair_take) begin
      a_q <= mul.a;
      b_q <= mul.b;
      acc <= '0;
    end else if (state == MUL_BUSY) begin
      acc <= step_red2[`NTM_DATA_WIDTH-1:0];
      b_q <= b_q << 1;
    end
  end
endmodule

`default_nettype wire

// ==== rtl/ntm_operand_latch.sv ====
//////////////////////////////////////////////////////////////////////
// NTM operand latch
// Gathers one A and one B in any order and offers them as a pair
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ntm_operand_latch (
  input  logic                CLK,
  input  logic                RST,
  input  logic                a_valid,
  input  logic                b_valid,
  input  ntm_data_pkg::data_t a_data,
  input  ntm_data_pkg::data_t b_data,
  ntm_mul_if.latch            mul
);
  import ntm_data_pkg::*;

  // Operand storage
  data_t a_q;
  data_t b_q;

  // One flag per operand
  logic a_full;
  logic b_full;

  // Flags cleared when the multiplier takes the pair
  // a new operand in the same cycle still wins
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_full <= 1'b0;
      b_full <= 1'b0;
    end else begin
      a_full <= a_valid | (a_full & ~mul.pair_take);
      b_full <= b_valid | (b_full & ~mul.pair_take);
    end
  end

  // Payload capture
  always_ff @(posedge CLK) begin
    if (a_valid) begin
      a_q <= a_data;
    end
    if (b_valid) begin
      b_q <= b_data;
    end
  end

  // Pair offered once both halves are in
  assign mul.pair_valid = a_full & b_full;
  assign mul.a          = a_q;
  assign mul.b          = b_q;
endmodule

`default_nettype wire

// ==== rtl/ntm_mul_if.sv ====
//////////////////////////////////////////////////////////////////////
// NTM multiplier link
// Operand pair, result and modulus between latch, multiplier and
// sequencer
//////////////////////////////////////////////////////////////////////

`default_nettype none

interface ntm_mul_if;
  import ntm_data_pkg::*;

  // Operand pair from the latch
  logic  pair_valid;
  data_t a;
  data_t b;
  logic  pair_take;

  // Result towards the sequencer
  logic  result_valid;
  data_t product;
  logic  result_take;

  // Held for the whole matrix
  data_t modulus;

  modport latch (output pair_valid, a, b, input pair_take);
  modport mult (input pair_valid, a, b, modulus, result_take,
                output pair_take, result_valid, product);
  modport seq (input pair_take, result_valid, product, output result_take, modulus);
endinterface

`default_nettype wire

// ==== rtl/ntm_ctrl_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// NTM control types
// FSM state encodings and the output credit counter
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ntm_config.svh"

package ntm_ctrl_pkg;

  // Sequencer FSM
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_RUN, SEQ_DRAIN} seq_state_t;

  // Multiplier FSM
  typedef enum logic [1:0] {MUL_FREE, MUL_BUSY, MUL_HOLD} mul_state_t;

  // Counts 0 up to NTM_OUT_CREDITS inclusive
  typedef logic [$clog2(`NTM_OUT_CREDITS+1)-1:0] credit_t;
endpackage

`default_nettype wire

// ==== rtl/ntm_data_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// NTM data types
// Element and matrix index vectors shared by the datapath
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ntm_config.svh"

package ntm_data_pkg;

  // One element, product or modulus
  typedef logic [`NTM_DATA_WIDTH-1:0] data_t;

  // Matrix size or row/column index
  typedef logic [`NTM_INDEX_WIDTH-1:0] index_t;

endpackage

`default_nettype wire

// ==== include/ntm_config.svh ====
//////////////////////////////////////////////////////////////////////
// NTM matrix multiplier configuration
// Element, index and output credit sizing for the modular multiplier
//////////////////////////////////////////////////////////////////////

`ifndef NTM_CONFIG_SVH
`define NTM_CONFIG_SVH

// Element and modulus width in bits
`define NTM_DATA_WIDTH 16

// Matrix size and index width in bits
`define NTM_INDEX_WIDTH 6

// Output credits granted to the consumer after reset
`define NTM_OUT_CREDITS 4

`endif
